//--- common/trap_pkg.sv
// Package with CSR addresses, widths, constant CSR values and trap unit structs.
package trap_pkg;

    // Data word, used for CSR data and interrupt vectors.
    typedef logic [31:0] xlen_t;
    // CSR address space.
    typedef logic [11:0] csr_addr_t;
    // Halfword program counter, bits 31 to 1.
    typedef logic [31:1] pc_t;
    // Word-aligned trap vector, bits 31 to 2.
    typedef logic [31:2] tvec_t;
    // Trap or interrupt number.
    typedef logic [4:0]  cause_t;

    // Machine trap setup.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    // Machine trap handling.
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    // Machine information, read-only.
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIPID      = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // MXL 32 with A, C, I and M.
    localparam xlen_t MISA_VALUE    = 32'h4000_1105;
    // Architecture ID of the core family.
    localparam xlen_t MARCHID_VALUE = 32'd37;
    // Single hart.
    localparam xlen_t HART_ID       = 32'd0;

    // Divider latency in cycles, reported in mipid.
    localparam logic [5:0] DIV_LATENCY = 6'd2;

    // Implementation ID.
    // Bit 31 fork flag, 23:22 fusion flags, 21:16 divider latency.
    // Bits 15:8 major, 7:4 minor, 3:0 patch.
    localparam xlen_t MIPID_VALUE = {
        1'b0,
        7'd0,
        1'b0,
        1'b0,
        DIV_LATENCY,
        8'd2,
        4'd0,
        4'd0
    };

    // Bit positions in mstatus.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    // Previous privilege is always machine mode.
    localparam logic [1:0] MSTATUS_MPP = 2'd3;

    // Interrupt numbers.
    localparam cause_t TIMER_IRQ  = 5'd7;
    // First of the 16 external lines.
    localparam cause_t EXT_IRQ_LO = 5'd16;

    // Edges of stable global enable before an interrupt can fire.
    localparam int MIE_SETTLE = 2;

    // CSR access from the pipeline.
    typedef struct packed {
        csr_addr_t addr;
        logic      we;
        xlen_t     wdata;
    } csr_req_t;

    // CSR read port result.
    typedef struct packed {
        logic  exists;
        logic  rdonly;
        xlen_t rdata;
    } csr_rsp_t;

    // Trap raised by the pipeline.
    typedef struct packed {
        logic   valid;
        cause_t cause;
        pc_t    epc;
    } trap_req_t;

    // Exception event after dispatch.
    typedef struct packed {
        logic   is_irq;
        logic   is_trap;
        cause_t cause;
        pc_t    epc;
    } exc_event_t;

endpackage

//--- csr/machine_csr_file.sv
// Machine CSR storage, read mux, write decode, trap entry and MRET.
`timescale 1ns/1ps

module machine_csr_file (
    input  logic                    clk,
    input  logic                    rst,
    // CSR read and write port.
    input  trap_pkg::csr_req_t      csr_req,
    // Dispatched exception event.
    input  trap_pkg::exc_event_t    exc,
    // MRET retires this cycle.
    input  logic                    mret,
    // Latched interrupt lines.
    input  trap_pkg::xlen_t         pending,
    // Read result for csr_req.addr.
    output trap_pkg::csr_rsp_t      csr_rsp,
    // Per-interrupt enables.
    output trap_pkg::xlen_t         mie_vec,
    // Global interrupt enable.
    output logic                    status_mie,
    // Trap vector.
    output trap_pkg::tvec_t         exc_tvec,
    // MRET return address.
    output trap_pkg::pc_t           ret_epc
);

    // mstatus MIE.
    logic status_mie_q;
    // mstatus MPIE.
    logic status_mpie_q;
    // mie register.
    trap_pkg::xlen_t mie_q;
    // mtvec, word aligned, direct mode only.
    trap_pkg::tvec_t mtvec_q;
    // mscratch.
    trap_pkg::xlen_t mscratch_q;
    // mepc, halfword aligned.
    trap_pkg::pc_t mepc_q;
    // mcause interrupt flag.
    logic mcause_int_q;
    // mcause number.
    trap_pkg::cause_t mcause_no_q;

    // Assembled read values.
    trap_pkg::xlen_t mstatus_val;
    trap_pkg::xlen_t mcause_val;
    trap_pkg::xlen_t mip_val;
    // Trap entry this cycle.
    logic trap_entry;

    assign trap_entry = exc.is_irq | exc.is_trap;

    // mstatus holds only MIE, MPIE and a fixed MPP.
    always_comb begin
        mstatus_val = '0;
        mstatus_val[trap_pkg::MSTATUS_MIE_BIT]  = status_mie_q;
        mstatus_val[trap_pkg::MSTATUS_MPIE_BIT] = status_mpie_q;
        // MPP sits at bits 12:11.
        mstatus_val[12:11] = trap_pkg::MSTATUS_MPP;
    end

    // Interrupt flag in bit 31, number in the low bits.
    assign mcause_val = {mcause_int_q, 26'd0, mcause_no_q};

    // Only enabled lines show as pending.
    assign mip_val = pending & mie_q;

    // Read mux.
    always_comb begin
        csr_rsp.exists = 1'b1;
        csr_rsp.rdonly = 1'b0;
        csr_rsp.rdata  = '0;
        case (csr_req.addr)
            trap_pkg::CSR_MSTATUS: begin
                csr_rsp.rdata = mstatus_val;
            end
            trap_pkg::CSR_MISA: begin
                // Fixed, writes are ignored.
                csr_rsp.rdata = trap_pkg::MISA_VALUE;
            end
            trap_pkg::CSR_MEDELEG,
            trap_pkg::CSR_MIDELEG,
            trap_pkg::CSR_MSTATUSH,
            trap_pkg::CSR_MTVAL: begin
                // No delegation, no trap value.
                csr_rsp.rdata = '0;
            end
            trap_pkg::CSR_MIE: begin
                csr_rsp.rdata = mie_q;
            end
            trap_pkg::CSR_MTVEC: begin
                csr_rsp.rdata = {mtvec_q, 2'b00};
            end
            trap_pkg::CSR_MSCRATCH: begin
                csr_rsp.rdata = mscratch_q;
            end
            trap_pkg::CSR_MEPC: begin
                csr_rsp.rdata = {mepc_q, 1'b0};
            end
            trap_pkg::CSR_MCAUSE: begin
                csr_rsp.rdata = mcause_val;
            end
            trap_pkg::CSR_MIP: begin
                csr_rsp.rdata = mip_val;
            end
            trap_pkg::CSR_MVENDORID,
            trap_pkg::CSR_MCONFIGPTR: begin
                // Read-only zero.
                csr_rsp.rdonly = 1'b1;
            end
            trap_pkg::CSR_MARCHID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = trap_pkg::MARCHID_VALUE;
            end
            trap_pkg::CSR_MIPID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = trap_pkg::MIPID_VALUE;
            end
            trap_pkg::CSR_MHARTID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = trap_pkg::HART_ID;
            end
            default: begin
                // Not implemented.
                csr_rsp.exists = 1'b0;
            end
        endcase
    end

    // Update priority: trap entry, then CSR write, then MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie_q  <= 1'b0;
            status_mpie_q <= 1'b0;
            mie_q         <= '0;
            mtvec_q       <= '0;
            mscratch_q    <= '0;
            mepc_q        <= '0;
            mcause_int_q  <= 1'b0;
            mcause_no_q   <= '0;
        end else if (trap_entry) begin
            // Save and disable the global enable.
            status_mpie_q <= status_mie_q;
            status_mie_q  <= 1'b0;
            mepc_q        <= exc.epc;
            mcause_int_q  <= exc.is_irq;
            mcause_no_q   <= exc.cause;
        end else if (csr_req.we) begin
            // Read-only and fixed CSRs fall to default.
            case (csr_req.addr)
                trap_pkg::CSR_MSTATUS: begin
                    status_mie_q  <= csr_req.wdata[trap_pkg::MSTATUS_MIE_BIT];
                    status_mpie_q <= csr_req.wdata[trap_pkg::MSTATUS_MPIE_BIT];
                end
                trap_pkg::CSR_MIE: begin
                    mie_q <= csr_req.wdata;
                end
                trap_pkg::CSR_MTVEC: begin
                    // Low two bits dropped.
                    mtvec_q <= csr_req.wdata[31:2];
                end
                trap_pkg::CSR_MSCRATCH: begin
                    mscratch_q <= csr_req.wdata;
                end
                trap_pkg::CSR_MEPC: begin
                    // Bit 0 dropped.
                    mepc_q <= csr_req.wdata[31:1];
                end
                trap_pkg::CSR_MCAUSE: begin
                    mcause_int_q <= csr_req.wdata[31];
                    mcause_no_q  <= csr_req.wdata[4:0];
                end
                default: begin
                end
            endcase
        end else if (mret) begin
            // Restore the global enable.
            status_mie_q <= status_mpie_q;
        end
    end

    assign mie_vec    = mie_q;
    assign status_mie = status_mie_q;
    // Direct mode, every trap goes to the base.
    assign exc_tvec   = mtvec_q;
    assign ret_epc    = mepc_q;

endmodule

//--- hw/irq_arbiter.sv
// Interrupt line sampling, masking, priority selection and enable settling.
`timescale 1ns/1ps

module irq_arbiter (
    input  logic                clk,
    input  logic                rst,
    // External interrupt lines 16 to 31.
    input  logic [15:0]         ext_irq,
    // Machine timer interrupt level.
    input  logic                timer_irq,
    // Per-interrupt enables from mie.
    input  trap_pkg::xlen_t     mie_vec,
    // Global interrupt enable from mstatus.
    input  logic                status_mie,
    // Latched pending vector, feeds mip.
    output trap_pkg::xlen_t     pending,
    // An enabled interrupt is waiting.
    output logic                irq_req,
    // Number of the winning interrupt.
    output trap_pkg::cause_t    irq_cause
);

    // Interrupt lines placed at their architectural positions.
    trap_pkg::xlen_t irq_lines;
    // Pending and enabled.
    trap_pkg::xlen_t masked;
    // History of the global enable.
    logic [trap_pkg::MIE_SETTLE-1:0] mie_hist;
    // Global enable stable long enough.
    logic irq_en;

    // Map lines into the 32-bit vector.
    always_comb begin
        irq_lines = '0;
        irq_lines[trap_pkg::TIMER_IRQ] = timer_irq;
        irq_lines[trap_pkg::EXT_IRQ_LO +: 16] = ext_irq;
    end

    // One register stage on all lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= irq_lines;
        end
    end

    assign masked = pending & mie_vec;

    // Lowest-numbered line wins.
    // Walk downward so the last hit is the lowest.
    always_comb begin
        irq_cause = '0;
        for (int i = $bits(trap_pkg::xlen_t) - 1; i >= 0; i--) begin
            if (masked[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

    // Shift in the global enable every edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= (mie_hist << 1) | status_mie;
        end
    end

    // Needs MIE now and at each of the last MIE_SETTLE edges.
    // Keeps a fresh MRET or CSR write from firing at once.
    assign irq_en = (&mie_hist) && status_mie;

    // Cause 0 never requests.
    assign irq_req = (irq_cause != '0) && irq_en;

endmodule

//--- hw/trap_dispatch.sv
// Exception dispatch between a pending interrupt and a pipeline trap.
`timescale 1ns/1ps

module trap_dispatch (
    // Enabled interrupt from the arbiter.
    input  logic                    irq_req,
    // Its interrupt number.
    input  trap_pkg::cause_t        irq_cause,
    // An instruction completes this cycle.
    input  logic                    retire,
    // Trap from the pipeline.
    input  trap_pkg::trap_req_t     trap_req,
    // Event to the CSR file.
    output trap_pkg::exc_event_t    exc,
    // Redirect to the trap vector.
    output logic                    exception
);

    // Interrupt needs a retiring instruction to attach to.
    logic take_irq;

    assign take_irq = irq_req && retire;

    always_comb begin
        exc = '0;
        // EPC of the trapping or retiring instruction.
        exc.epc = trap_req.epc;
        if (take_irq) begin
            // Interrupt beats a trap in the same cycle.
            exc.is_irq = 1'b1;
            exc.cause  = irq_cause;
        end else if (trap_req.valid) begin
            // Synchronous trap from the pipeline.
            exc.is_trap = 1'b1;
            exc.cause   = trap_req.cause;
        end
    end

    // Combinational, same cycle as the request.
    assign exception = exc.is_irq | exc.is_trap;

endmodule

//--- hw/trap_unit.sv
// Top level of the machine trap unit joining arbiter, CSR file and dispatch.
`timescale 1ns/1ps

module trap_unit (
    input  logic                    clk,
    input  logic                    rst,
    // CSR access from the pipeline.
    input  trap_pkg::csr_req_t      csr_req,
    // Trap from the pipeline.
    input  trap_pkg::trap_req_t     trap_req,
    // MRET strobe.
    input  logic                    mret,
    // Instruction completes this cycle.
    input  logic                    retire,
    // External interrupt lines 16 to 31.
    input  logic [15:0]             ext_irq,
    // Machine timer interrupt level.
    input  logic                    timer_irq,
    // CSR read result.
    output trap_pkg::csr_rsp_t      csr_rsp,
    // Redirect to the trap vector.
    output logic                    exception,
    // Trap vector.
    output trap_pkg::tvec_t         exc_tvec,
    // MRET return address.
    output trap_pkg::pc_t           ret_epc
);

    // Enables from the CSR file.
    trap_pkg::xlen_t      mie_vec;
    logic                 status_mie;
    // Latched interrupt lines.
    trap_pkg::xlen_t      pending;
    // Arbiter result.
    logic                 irq_req;
    trap_pkg::cause_t     irq_cause;
    // Dispatched event.
    trap_pkg::exc_event_t exc;

    irq_arbiter irq_arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .ext_irq    (ext_irq),
        .timer_irq  (timer_irq),
        .mie_vec    (mie_vec),
        .status_mie (status_mie),
        .pending    (pending),
        .irq_req    (irq_req),
        .irq_cause  (irq_cause)
    );

    machine_csr_file machine_csr_file_i (
        .clk        (clk),
        .rst        (rst),
        .csr_req    (csr_req),
        .exc        (exc),
        .mret       (mret),
        .pending    (pending),
        .csr_rsp    (csr_rsp),
        .mie_vec    (mie_vec),
        .status_mie (status_mie),
        .exc_tvec   (exc_tvec),
        .ret_epc    (ret_epc)
    );

    trap_dispatch trap_dispatch_i (
        .irq_req    (irq_req),
        .irq_cause  (irq_cause),
        .retire     (retire),
        .trap_req   (trap_req),
        .exc        (exc),
        .exception  (exception)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build the trap unit testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_trap_unit -f src.f -o tb_trap_unit
./obj_dir/tb_trap_unit > sim.log 2>&1
cat sim.log
if grep -q '^All tests passed!$' sim.log; then
    exit 0
else
    exit 1
fi

//--- src.f
common/trap_pkg.sv
hw/irq_arbiter.sv
hw/trap_dispatch.sv
csr/machine_csr_file.sv
hw/trap_unit.sv
testbench/tb_trap_unit.sv

//--- testbench/tb_trap_unit.sv
// Directed-test testbench for the trap unit with test tasks, checks, watchdog and summary.
`timescale 1ns/1ps

module tb_trap_unit;

    logic                  clk;
    logic                  rst;
    trap_pkg::csr_req_t    csr_req;
    trap_pkg::trap_req_t   trap_req;
    logic                  mret;
    logic                  retire;
    logic [15:0]           ext_irq;
    logic                  timer_irq;
    trap_pkg::csr_rsp_t    csr_rsp;
    logic                  exception;
    trap_pkg::tvec_t       exc_tvec;
    trap_pkg::pc_t         ret_epc;

    // Running totals.
    int     errors;
    int     failed_tests;
    // Random write data.
    integer seed;

    trap_unit trap_unit_i (
        .clk       (clk),
        .rst       (rst),
        .csr_req   (csr_req),
        .trap_req  (trap_req),
        .mret      (mret),
        .retire    (retire),
        .ext_irq   (ext_irq),
        .timer_irq (timer_irq),
        .csr_rsp   (csr_rsp),
        .exception (exception),
        .exc_tvec  (exc_tvec),
        .ret_epc   (ret_epc)
    );

    // 10 ns clock.
    always #5 clk = ~clk;

    // Five tests, 200 cycles each, 10 ns per cycle.
    initial begin
        int limit_ns;
        limit_ns = 5 * 200 * 10;
        #(limit_ns);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s read 0x%h, expected 0x%h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Write lands at the second edge.
    task automatic csr_write(input trap_pkg::csr_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        csr_req <= {addr, 1'b1, data};
        @(posedge clk);
        csr_req <= {addr, 1'b0, 32'd0};
    endtask

    // Combinational read, sampled mid-cycle.
    task automatic csr_read(input trap_pkg::csr_addr_t addr, output trap_pkg::csr_rsp_t rsp);
        @(posedge clk);
        csr_req <= {addr, 1'b0, 32'd0};
        @(negedge clk);
        rsp = csr_rsp;
    endtask

    task automatic expect_csr(input string what, input trap_pkg::csr_addr_t addr,
                              input logic [31:0] exp);
        trap_pkg::csr_rsp_t rsp;
        csr_read(addr, rsp);
        if (!rsp.exists) begin
            $display("CSR %s was reported as not implemented", what);
            errors++;
        end
        check_eq(what, rsp.rdata, exp);
    endtask

    // Holds until exception rises, at most 20 cycles.
    task automatic wait_exception(output logic seen);
        int count;
        seen  = 1'b0;
        count = 0;
        while (!seen && count < 20) begin
            @(negedge clk);
            seen = (exception === 1'b1);
            count++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: FAILED", name);
            failed_tests++;
        end
    endtask

    task automatic test_reset_ids();
        int start;
        trap_pkg::csr_rsp_t rsp;
        start = errors;
        expect_csr("misa", trap_pkg::CSR_MISA, 32'h4000_1105);
        expect_csr("marchid", trap_pkg::CSR_MARCHID, 32'd37);
        expect_csr("mipid", trap_pkg::CSR_MIPID, 32'h0002_0200);
        expect_csr("mhartid", trap_pkg::CSR_MHARTID, 32'd0);
        // Only MPP, bits 12:11.
        expect_csr("mstatus", trap_pkg::CSR_MSTATUS, 32'h0000_1800);
        expect_csr("mie", trap_pkg::CSR_MIE, 32'd0);
        expect_csr("mtvec", trap_pkg::CSR_MTVEC, 32'd0);
        expect_csr("mepc", trap_pkg::CSR_MEPC, 32'd0);
        expect_csr("mcause", trap_pkg::CSR_MCAUSE, 32'd0);
        csr_read(12'h7c0, rsp);
        if (rsp.exists) begin
            $display("unknown CSR 0x7c0 was reported as implemented");
            errors++;
        end
        csr_read(trap_pkg::CSR_MARCHID, rsp);
        if (!rsp.rdonly) begin
            $display("marchid was not reported as read-only");
            errors++;
        end
        end_test("reset_ids", start);
    endtask

    task automatic test_write_read();
        int start;
        trap_pkg::xlen_t data;
        start = errors;
        data = $random(seed);
        csr_write(trap_pkg::CSR_MSCRATCH, data);
        expect_csr("mscratch", trap_pkg::CSR_MSCRATCH, data);
        data = $random(seed);
        csr_write(trap_pkg::CSR_MIE, data);
        expect_csr("mie", trap_pkg::CSR_MIE, data);
        // Word aligned.
        data = $random(seed);
        csr_write(trap_pkg::CSR_MTVEC, data);
        expect_csr("mtvec", trap_pkg::CSR_MTVEC, {data[31:2], 2'b00});
        // Halfword aligned.
        data = $random(seed);
        csr_write(trap_pkg::CSR_MEPC, data);
        expect_csr("mepc", trap_pkg::CSR_MEPC, {data[31:1], 1'b0});
        data = $random(seed);
        csr_write(trap_pkg::CSR_MARCHID, data);
        expect_csr("marchid", trap_pkg::CSR_MARCHID, 32'd37);
        end_test("write_read", start);
    endtask

    task automatic test_trap_entry();
        int start;
        trap_pkg::xlen_t epc;
        start = errors;
        epc   = 32'h0000_2468;
        csr_write(trap_pkg::CSR_MTVEC, 32'h0000_1000);
        csr_write(trap_pkg::CSR_MSTATUS, 32'h0000_0008);
        // Cause 2, illegal instruction.
        @(posedge clk);
        trap_req <= {1'b1, 5'd2, epc[31:1]};
        @(negedge clk);
        if (exception !== 1'b1) begin
            $display("exception did not rise with the trap request");
            errors++;
        end
        check_eq("exc_tvec", {exc_tvec, 2'b00}, 32'h0000_1000);
        @(posedge clk);
        trap_req <= '0;
        expect_csr("mcause", trap_pkg::CSR_MCAUSE, 32'd2);
        expect_csr("mepc", trap_pkg::CSR_MEPC, epc);
        // MIE clear, MPIE set.
        expect_csr("mstatus", trap_pkg::CSR_MSTATUS, 32'h0000_1880);
        end_test("trap_entry", start);
    endtask

    task automatic test_mret();
        int start;
        trap_pkg::xlen_t epc;
        start = errors;
        // EPC saved by the trap entry test.
        epc   = 32'h0000_2468;
        expect_csr("mepc", trap_pkg::CSR_MEPC, epc);
        check_eq("ret_epc", {ret_epc, 1'b0}, epc);
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
        // MIE back from MPIE.
        expect_csr("mstatus", trap_pkg::CSR_MSTATUS, 32'h0000_1888);
        end_test("mret", start);
    endtask

    task automatic test_interrupts();
        int start;
        logic seen;
        start = errors;
        // Lines 7, 17 and 20 enabled, 16 masked.
        csr_write(trap_pkg::CSR_MIE, 32'h0012_0080);
        csr_write(trap_pkg::CSR_MSTATUS, 32'h0000_0008);
        // Lines 16, 17 and 20 raised.
        @(posedge clk);
        ext_irq <= 16'h0013;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (exception !== 1'b0) begin
            $display("interrupt fired without a retiring instruction");
            errors++;
        end
        expect_csr("mip", trap_pkg::CSR_MIP, 32'h0012_0000);
        @(posedge clk);
        retire <= 1'b1;
        @(negedge clk);
        if (exception !== 1'b1) begin
            $display("interrupt did not fire with retire high");
            errors++;
        end
        @(posedge clk);
        retire <= 1'b0;
        expect_csr("mcause", trap_pkg::CSR_MCAUSE, 32'h8000_0011);
        // Timer joins while MRET restores the enable.
        @(posedge clk);
        timer_irq <= 1'b1;
        mret      <= 1'b1;
        @(posedge clk);
        mret   <= 1'b0;
        retire <= 1'b1;
        wait_exception(seen);
        if (!seen) begin
            $display("no interrupt was taken after MRET with the timer line high");
            errors++;
        end
        @(posedge clk);
        retire <= 1'b0;
        expect_csr("mcause", trap_pkg::CSR_MCAUSE, 32'h8000_0007);
        expect_csr("mip", trap_pkg::CSR_MIP, 32'h0012_0080);
        @(posedge clk);
        ext_irq   <= '0;
        timer_irq <= 1'b0;
        end_test("interrupts", start);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        csr_req      = '0;
        trap_req     = '0;
        mret         = 1'b0;
        retire       = 1'b0;
        ext_irq      = '0;
        timer_irq    = 1'b0;
        errors       = 0;
        failed_tests = 0;
        seed         = 32'h8c56_270e;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_ids();
        test_write_read();
        test_trap_entry();
        test_mret();
        test_interrupts();
        $display("%0d tests run, %0d failed, %0d errors", 5, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
